// ==== hdl/cpu_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, encodings and stage bundles
// for the five-stage MIPS integer pipeline.
// Modules pull it in with a wildcard import.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;   // writeback takes load data
        logic    alu_src_imm;  // second ALU operand is the immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;    // sign-extended
        reg_addr_t dest;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
        word_t     pc;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     data;
        word_t     pc;
    } commit_t;

endpackage

// ==== hdl/decode_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage with control bits, operand read
// with memory-stage forwarding and early branch resolve.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  logic    stall,
    input  logic    fwd_rs,
    input  logic    fwd_rt,
    input  word_t   if_instr,
    input  word_t   if_pc,
    input  word_t   mem_fwd,
    input  commit_t commit,
    output id_ex_t  id_ex,
    output logic    branch_taken,
    output word_t   branch_target
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t dest;
    word_t     rf_rs_val;
    word_t     rf_rt_val;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;
    ctrl_t     ctrl;
    logic      known;
    logic      is_beq;
    logic      is_bne;
    logic      operands_eq;

    assign opcode  = opcode_e'(if_instr[31:26]);
    assign funct   = funct_e'(if_instr[5:0]);
    assign rs_addr = if_instr[25:21];
    assign rt_addr = if_instr[20:16];
    assign imm     = {{16{if_instr[15]}}, if_instr[15:0]};

    register_file u_regs (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .commit    (commit),
        .rs_val    (rf_rs_val),
        .rt_val    (rf_rt_val)
    );

    always_comb
    begin
        ctrl   = '0;
        known  = 1'b1;
        is_beq = 1'b0;
        is_bne = 1'b0;
        dest   = rt_addr;   // I-type writes rt
        case (opcode)
            OP_RTYPE:
            begin
                dest           = if_instr[15:11];
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_BNE:  is_bne = 1'b1;
            default: known  = 1'b0;
        endcase
        if (!known || dest == 5'd0)
            ctrl.reg_write = 1'b0;   // r0 writes die here
    end

    assign rs_val      = fwd_rs ? mem_fwd : rf_rs_val;
    assign rt_val      = fwd_rt ? mem_fwd : rf_rt_val;
    assign operands_eq = (rs_val == rt_val);

    assign branch_taken  = !stall && ((is_beq && operands_eq) || (is_bne && !operands_eq));
    assign branch_target = if_pc + 32'd4 + {imm[29:0], 2'b00};

    always_comb
    begin
        id_ex = '0;
        if (!stall && known)
        begin
            id_ex.valid  = 1'b1;
            id_ex.ctrl   = ctrl;
            id_ex.rs_val = rs_val;
            id_ex.rt_val = rt_val;
            id_ex.imm    = imm;
            id_ex.dest   = dest;
            id_ex.pc     = if_pc;
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX register, ALU and the EX/MEM register.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    id_ex_t id_ex_q;
    word_t  op_b;
    word_t  alu_y;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            id_ex_q <= '0;
        else
            id_ex_q <= id_ex;
    end

    assign op_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : id_ex_q.rt_val;

    always_comb
    begin
        case (id_ex_q.ctrl.alu_op)
            ALU_ADD: alu_y = id_ex_q.rs_val + op_b;   // also lw/sw address
            ALU_SUB: alu_y = id_ex_q.rs_val - op_b;
            ALU_AND: alu_y = id_ex_q.rs_val & op_b;
            ALU_OR:  alu_y = id_ex_q.rs_val | op_b;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(id_ex_q.rs_val) < $signed(op_b)};
            default: alu_y = '0;
        endcase
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            ex_mem <= '0;
        else
        begin
            ex_mem.valid      <= id_ex_q.valid;
            ex_mem.ctrl       <= id_ex_q.ctrl;
            ex_mem.alu_result <= alu_y;
            ex_mem.store_data <= id_ex_q.rt_val;
            ex_mem.dest       <= id_ex_q.dest;
            ex_mem.pc         <= id_ex_q.pc;
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter and the IF/ID register.
// Holds on stall, redirects on a taken branch.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fetch_stage
    import cpu_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0040_0000
)
(
    input  logic  SYS_clk,
    input  logic  SYS_reset,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    input  word_t imem_data,
    output word_t imem_addr,
    output word_t if_instr,
    output word_t if_pc
);

    word_t pc;
    word_t pc_next;

    assign pc_next   = branch_taken ? branch_target : pc + 32'd4;
    assign imem_addr = pc;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc       <= RESET_PC;
            if_instr <= '0;   // all-zero word decodes as a bubble
            if_pc    <= '0;
        end
        else if (!stall)
        begin
            pc       <= pc_next;
            if_instr <= branch_taken ? '0 : imem_data;   // squash slot behind branch
            if_pc    <= pc;
        end
    end

endmodule

// ==== hdl/hazard_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stall counter and memory-stage
// forward selects for the rs/rt operands.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module hazard_unit
    import cpu_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  word_t   if_instr,
    input  id_ex_t  id_ex,
    input  ex_mem_t ex_mem,
    output logic    stall,
    output logic    fwd_rs,
    output logic    fwd_rt
);

    reg_addr_t  rs_addr;
    reg_addr_t  rt_addr;
    logic       use_rs;
    logic       use_rt;
    logic       ex_write;     // instruction now in execute writes a register
    logic       ex_load;
    reg_addr_t  ex_dest;
    logic       ex_hit;
    logic       mem_hit_rs;
    logic       mem_hit_rt;
    logic [1:0] stall_need;
    logic [1:0] stall_now;
    logic [1:0] stall_cnt;

    assign rs_addr = if_instr[25:21];
    assign rt_addr = if_instr[20:16];

    always_comb
    begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (opcode_e'(if_instr[31:26]))
            OP_RTYPE, OP_BEQ, OP_BNE, OP_SW:
            begin
                use_rs = 1'b1;
                use_rt = 1'b1;   // sw needs rt as store data
            end
            OP_ADDI, OP_LW: use_rs = 1'b1;
            default:        use_rs = 1'b0;
        endcase
    end

    // tracks what decode hands to execute including bubbles
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ex_write <= 1'b0;
            ex_load  <= 1'b0;
            ex_dest  <= '0;
        end
        else
        begin
            ex_write <= id_ex.valid && id_ex.ctrl.reg_write;
            ex_load  <= id_ex.ctrl.mem_read;
            ex_dest  <= id_ex.dest;
        end
    end

    assign ex_hit = ex_write && ((use_rs && ex_dest == rs_addr) ||
                                 (use_rt && ex_dest == rt_addr));
    assign mem_hit_rs = ex_mem.valid && ex_mem.ctrl.reg_write && use_rs && ex_mem.dest == rs_addr;
    assign mem_hit_rt = ex_mem.valid && ex_mem.ctrl.reg_write && use_rt && ex_mem.dest == rt_addr;

    always_comb
    begin
        if (ex_hit && ex_load)
            stall_need = 2'd2;
        else if (ex_hit || ((mem_hit_rs || mem_hit_rt) && ex_mem.ctrl.mem_read))
            stall_need = 2'd1;
        else
            stall_need = 2'd0;
    end

    assign stall_now = (stall_cnt != 2'd0) ? stall_cnt : stall_need;
    assign stall     = (stall_now != 2'd0);

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            stall_cnt <= 2'd0;
        else if (stall)
            stall_cnt <= stall_now - 2'd1;   // count down remaining stall cycles
    end

    assign fwd_rs = mem_hit_rs && !ex_mem.ctrl.mem_read;   // load data not ready here
    assign fwd_rt = mem_hit_rt && !ex_mem.ctrl.mem_read;

endmodule

// ==== hdl/memory_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory access and the MEM/WB register.
// Its output is the commit bundle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module memory_stage
    import cpu_pkg::*;
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  ex_mem_t ex_mem,
    output word_t   mem_fwd,
    output commit_t commit
);

    localparam int AW = $clog2(DMEM_WORDS);

    word_t         dmem [DMEM_WORDS];
    logic [AW-1:0] dmem_idx;
    word_t         load_data;
    word_t         wb_data;

    assign dmem_idx  = ex_mem.alu_result[AW+1:2];   // byte address to word index
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.valid && ex_mem.ctrl.mem_write)
            dmem[dmem_idx] <= ex_mem.store_data;
    end

    assign wb_data = ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
    assign mem_fwd = ex_mem.alu_result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            commit <= '0;
        else
        begin
            commit.valid <= ex_mem.valid && ex_mem.ctrl.reg_write;
            commit.dest  <= ex_mem.dest;
            commit.data  <= wb_data;
            commit.pc    <= ex_mem.pc;
        end
    end

endmodule

// ==== hdl/mips_pipeline.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the MIPS core. Instruction memory sits
// outside on imem_addr/imem_data; every retired
// register write shows up on commit for one cycle.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mips_pipeline
    import cpu_pkg::*;
#(
    parameter word_t RESET_PC   = 32'h0040_0000,
    parameter int    DMEM_WORDS = 256
)
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  word_t   imem_data,
    output word_t   imem_addr,
    output commit_t commit
);

    word_t   if_instr;
    word_t   if_pc;
    word_t   branch_target;
    word_t   mem_fwd;
    logic    branch_taken;
    logic    stall;
    logic    fwd_rs;
    logic    fwd_rt;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_data     (imem_data),
        .imem_addr     (imem_addr),
        .if_instr      (if_instr),
        .if_pc         (if_pc)
    );

    decode_stage u_decode (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .if_instr      (if_instr),
        .if_pc         (if_pc),
        .mem_fwd       (mem_fwd),
        .commit        (commit),
        .id_ex         (id_ex),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    hazard_unit u_hazard (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .if_instr  (if_instr),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .stall     (stall),
        .fwd_rs    (fwd_rs),
        .fwd_rt    (fwd_rt)
    );

    execute_stage u_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem)
    );

    memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .ex_mem    (ex_mem),
        .mem_fwd   (mem_fwd),
        .commit    (commit)
    );

endmodule

// ==== hdl/register_file.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file with two read ports.
// Written from the commit bundle; r0 reads zero.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module register_file
    import cpu_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  commit_t   commit,
    output word_t     rs_val,
    output word_t     rt_val
);

    word_t regs [32];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (commit.valid && commit.dest != 5'd0)
            regs[commit.dest] <= commit.data;
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == 5'd0)
            return '0;
        else if (commit.valid && commit.dest == addr)
            return commit.data;   // same-cycle write shows through
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        rs_val = read_port(rs_addr);
        rt_val = read_port(rt_addr);
    end

endmodule

// ==== project.f ====
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipeline.sv
testbench/pipeline_properties.sv
testbench/tb_clock.sv
testbench/tb_top.sv

// ==== testbench/pipeline_properties.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the pipeline ports.
// Bound into mips_pipeline by the testbench.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module pipeline_properties
    import cpu_pkg::*;
#(
    parameter word_t RESET_PC = 32'h0040_0000
)
(
    input logic    SYS_clk,
    input logic    SYS_reset,
    input word_t   imem_addr,
    input commit_t commit
);

    int error_count = 0;   // read by the testbench at the end

    reset_state: assert property (@(posedge SYS_clk)
        SYS_reset |-> (imem_addr == RESET_PC && !commit.valid))
    else
    begin
        $error("imem_addr or commit.valid wrong while reset is held");
        error_count = error_count + 1;
    end

    first_edge: assert property (@(posedge SYS_clk)
        $fell(SYS_reset) |-> (imem_addr == RESET_PC && !commit.valid))
    else
    begin
        $error("imem_addr or commit.valid wrong on the first edge after reset");
        error_count = error_count + 1;
    end

    word_aligned: assert property (@(posedge SYS_clk) imem_addr[1:0] == 2'b00)
    else
    begin
        $error("imem_addr is not word-aligned");
        error_count = error_count + 1;
    end

    // r0 writes are dropped in decode
    no_r0_commit: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit.valid |-> commit.dest != 5'd0)
    else
    begin
        $error("a commit targets register 0");
        error_count = error_count + 1;
    end

endmodule

// ==== testbench/tb_clock.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and power-on reset.
// Reset is released on a rising edge.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clock
#(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
)
(
    output logic SYS_clk,
    output logic SYS_reset
);

    initial
    begin
        SYS_clk = 1'b0;
        forever #(PERIOD_NS / 2) SYS_clk = ~SYS_clk;
    end

    initial
    begin
        SYS_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge SYS_clk);
        SYS_reset <= 1'b0;   // low from the third rising edge on
    end

endmodule

// ==== testbench/tb_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the MIPS pipeline. Serves a fixed
// program from a ROM and checks every commit
// against a table worked out from the ISA rules.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_top
    import cpu_pkg::*;
();

    localparam word_t RESET_PC     = 32'h0040_0000;
    localparam int    CLK_PERIOD   = 40;
    localparam int    PROG_LEN     = 27;
    localparam int    DRAIN_CYCLES = 10;

    logic    SYS_clk;
    logic    SYS_reset;
    word_t   imem_addr;
    word_t   imem_data;
    commit_t commit;
    word_t   rom [PROG_LEN];
    word_t   rom_idx;
    commit_t expected [$];
    int      n_seen = 0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset)
    );

    mips_pipeline #(.RESET_PC(RESET_PC), .DMEM_WORDS(256)) dut (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .commit    (commit)
    );

    bind mips_pipeline pipeline_properties #(.RESET_PC(RESET_PC)) u_props (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .commit    (commit)
    );

    assign rom_idx   = (imem_addr - RESET_PC) >> 2;
    assign imem_data = (rom_idx < PROG_LEN) ? rom[rom_idx] : '0;   // past the end is a bubble

    function automatic word_t rtype_word(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(opcode_e op, reg_addr_t rt, reg_addr_t rs,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic expect_commit(input int slot, input reg_addr_t dest, input word_t data);
        commit_t entry;
        entry.valid = 1'b1;
        entry.dest  = dest;
        entry.data  = data;
        entry.pc    = RESET_PC + 32'(slot * 4);
        expected.push_back(entry);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    initial
    begin
        rom[0]  = itype_word(OP_ADDI, 5'd1, 5'd0, 16'h0f0f);
        rom[1]  = itype_word(OP_ADDI, 5'd2, 5'd1, 16'hff00);   // minus 0x100
        rom[2]  = rtype_word(FN_ADD, 5'd3, 5'd1, 5'd2);
        rom[3]  = rtype_word(FN_SUB, 5'd4, 5'd2, 5'd3);        // goes negative
        rom[4]  = rtype_word(FN_AND, 5'd5, 5'd4, 5'd3);
        rom[5]  = rtype_word(FN_OR, 5'd6, 5'd5, 5'd1);
        rom[6]  = rtype_word(FN_SLT, 5'd7, 5'd4, 5'd6);
        rom[7]  = rtype_word(FN_SLT, 5'd8, 5'd6, 5'd4);
        rom[8]  = itype_word(OP_SW, 5'd6, 5'd0, 16'd8);
        rom[9]  = itype_word(OP_LW, 5'd9, 5'd0, 16'd8);
        rom[10] = rtype_word(FN_ADD, 5'd10, 5'd9, 5'd1);       // load-use costs 2 stalls
        rom[11] = itype_word(OP_ADDI, 5'd11, 5'd0, 16'd16);
        rom[12] = itype_word(OP_SW, 5'd10, 5'd11, 16'd0);
        rom[13] = itype_word(OP_LW, 5'd12, 5'd11, 16'd0);
        rom[14] = itype_word(OP_ADDI, 5'd13, 5'd0, 16'd3);
        rom[15] = rtype_word(FN_SUB, 5'd14, 5'd12, 5'd1);      // load two ahead
        rom[16] = itype_word(OP_BEQ, 5'd10, 5'd12, 16'd1);     // taken
        rom[17] = itype_word(OP_ADDI, 5'd15, 5'd0, 16'd99);    // squashed
        rom[18] = itype_word(OP_BNE, 5'd1, 5'd13, 16'd1);      // taken
        rom[19] = itype_word(OP_ADDI, 5'd16, 5'd0, 16'd77);    // squashed
        rom[20] = itype_word(OP_BEQ, 5'd1, 5'd13, 16'd1);      // falls through
        rom[21] = itype_word(OP_ADDI, 5'd17, 5'd13, 16'd1);
        rom[22] = itype_word(OP_BNE, 5'd0, 5'd17, 16'd1);      // needs forwarded r17
        rom[23] = itype_word(OP_ADDI, 5'd18, 5'd0, 16'd55);    // squashed
        rom[24] = itype_word(OP_ADDI, 5'd0, 5'd0, 16'd123);    // r0 write never commits
        rom[25] = rtype_word(FN_ADD, 5'd19, 5'd0, 5'd0);
        rom[26] = itype_word(OP_BEQ, 5'd0, 5'd0, 16'hffff);    // spin here

        expect_commit(0, 5'd1, 32'h0000_0f0f);
        expect_commit(1, 5'd2, 32'h0000_0e0f);
        expect_commit(2, 5'd3, 32'h0000_1d1e);
        expect_commit(3, 5'd4, 32'hffff_f0f1);
        expect_commit(4, 5'd5, 32'h0000_1010);
        expect_commit(5, 5'd6, 32'h0000_1f1f);
        expect_commit(6, 5'd7, 32'h0000_0001);
        expect_commit(7, 5'd8, 32'h0000_0000);
        expect_commit(9, 5'd9, 32'h0000_1f1f);
        expect_commit(10, 5'd10, 32'h0000_2e2e);
        expect_commit(11, 5'd11, 32'h0000_0010);
        expect_commit(13, 5'd12, 32'h0000_2e2e);
        expect_commit(14, 5'd13, 32'h0000_0003);
        expect_commit(15, 5'd14, 32'h0000_1f1f);
        expect_commit(21, 5'd17, 32'h0000_0004);
        expect_commit(25, 5'd19, 32'h0000_0000);
    end

    // commit changes on the rising edge and is sampled on the falling one
    initial
    begin : check_commits
        string field;
        word_t got;
        word_t want;
        @(negedge SYS_reset);
        while (n_seen < expected.size())
        begin
            @(negedge SYS_clk);
            if (commit.valid)
            begin
                assert (commit.dest == expected[n_seen].dest &&
                        commit.data == expected[n_seen].data &&
                        commit.pc == expected[n_seen].pc)
                    n_seen = n_seen + 1;
                else
                begin
                    if (commit.dest != expected[n_seen].dest)
                    begin
                        field = "dest";
                        got   = 32'(commit.dest);
                        want  = 32'(expected[n_seen].dest);
                    end
                    else if (commit.data != expected[n_seen].data)
                    begin
                        field = "data";
                        got   = commit.data;
                        want  = expected[n_seen].data;
                    end
                    else
                    begin
                        field = "pc";
                        got   = commit.pc;
                        want  = expected[n_seen].pc;
                    end
                    abort_run($sformatf(
                        "ERR at %0d ns: commit %0d has wrong %s, got %h, expected %h",
                        $time, n_seen, field, got, want));
                end
            end
        end
        repeat (DRAIN_CYCLES)   // core should now spin on the final beq
        begin
            @(negedge SYS_clk);
            assert (!commit.valid)
            else
                abort_run($sformatf("ERR at %0d ns: unexpected commit to r%0d from pc %h",
                                    $time, commit.dest, commit.pc));
        end
        if (dut.u_props.error_count == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
            abort_run("the bound pipeline properties reported failures");
    end

    initial
    begin : watchdog
        @(negedge SYS_reset);
        #((expected.size() * 8 + 50) * CLK_PERIOD);
        abort_run($sformatf("watchdog expired: commits stopped after %0d of %0d expected",
                            n_seen, expected.size()));
    end

endmodule
